// File: compile.f
+incdir+verilog
verilog/fe_pkg.sv
verilog/fe_redirect_sel.sv
verilog/fe_pc_ctrl.sv
verilog/fe_btb.sv
verilog/fe_fetch_pipe.sv
verilog/fe_top.sv
tb/fe_checker.sv
tb/tb_fe_top.sv

// File: tb/fe_checker.sv
/* fetch block checker */
`timescale 1ns/1ps
`include "fe_defines.svh"

module fe_checker
  import fe_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_reset_n,
  input  fe_commit_t             i_commit,
  input  fe_br_upd_t             i_br_upd,
  input  fe_fetch_req_t          i_fetch_req,
  input  fe_fetch_blk_t          i_fetch_blk,
  input  logic                   i_ibuf_ready,
  input  logic                   i_exp_valid,
  input  logic [`FE_VADDR_W-1:0] i_exp_vaddr,
  output logic                   o_busy,
  output int                     o_errors,
  output int                     o_checks
);

  typedef logic [`FE_VADDR_W-1:0] vaddr_t;

  vaddr_t exp_q [$];        // restart addresses, oldest first
  vaddr_t prev_vaddr;       // last taken block
  logic   pending;          // next taken block follows a redirect
  logic   r_busy;
  int     since_reset;      // cycles since reset release, stops at 2
  int     errors = 0;
  int     checks = 0;

  // reference btb, one entry per index
  logic   ref_valid [`FE_BTB_ENTRIES];
  vaddr_t ref_blk   [`FE_BTB_ENTRIES];
  vaddr_t ref_tgt   [`FE_BTB_ENTRIES];

  function automatic vaddr_t align_blk(input vaddr_t a);
    return a - (a % `FE_BLK_BYTES);
  endfunction

  function automatic int btb_index(input vaddr_t a);
    return int'((a / `FE_BLK_BYTES) % `FE_BTB_ENTRIES);
  endfunction

  // successor block, skipping blocks the btb predicts away
  function automatic vaddr_t next_vaddr(input vaddr_t prev);
    vaddr_t a;
    int     hops;
    a    = prev + `FE_BLK_BYTES;
    hops = 0;
    while (hops < 4 && ref_valid[btb_index(a)] && ref_blk[btb_index(a)] == a) begin
      a    = ref_tgt[btb_index(a)];
      hops = hops + 1;
    end
    return a;
  endfunction

  // ==================================================
  // taken block checks
  // ==================================================
  task automatic check_block(input vaddr_t vaddr, input logic [`FE_BLK_W-1:0] data);
    vaddr_t               exp_vaddr;
    logic [`FE_BLK_W-1:0] exp_data;
    exp_data = {2{vaddr[`FE_BLK_W/2-1:0]}};  // memory repeats the address
    if (pending) begin
      if (exp_q.size() == 0) begin
        $display("block %h taken after a redirect with no restart address known, t=%0t",
                 vaddr, $time);
        errors++;
        exp_vaddr = vaddr;
      end else begin
        exp_vaddr = exp_q.pop_front();
      end
      pending = 1'b0;
    end else begin
      exp_vaddr = next_vaddr(prev_vaddr);
    end
    checks++;
    if (vaddr !== exp_vaddr) begin
      $display("ERROR t=%0t o_fetch_blk.vaddr expected %h actual %h", $time, exp_vaddr, vaddr);
      errors++;
    end
    if (data !== exp_data) begin
      $display("ERROR t=%0t o_fetch_blk.data expected %h actual %h", $time, exp_data, data);
      errors++;
    end
    prev_vaddr = vaddr;
  endtask

  // first request one idle cycle after reset
  task automatic check_first_req();
    logic exp_req;
    since_reset++;
    exp_req = (since_reset == 2);
    checks++;
    if (i_fetch_req.valid !== exp_req) begin
      $display("ERROR t=%0t o_fetch_req.valid expected %0b actual %0b",
               $time, exp_req, i_fetch_req.valid);
      errors++;
    end
    if (exp_req && i_fetch_req.vaddr !== `FE_PC_INIT) begin
      $display("ERROR t=%0t o_fetch_req.vaddr expected %h actual %h",
               $time, `FE_PC_INIT, i_fetch_req.vaddr);
      errors++;
    end
  endtask

  always @(posedge i_clk) begin
    int upd_idx;
    if (!i_reset_n) begin
      exp_q.delete();
      exp_q.push_back(`FE_PC_INIT);   // first block after reset
      pending     = 1'b1;
      since_reset = 0;
      foreach (ref_valid[i])
        ref_valid[i] = 1'b0;
    end else begin
      if (since_reset < 2) begin
        check_first_req();
      end
      if (i_exp_valid) begin
        exp_q.push_back(i_exp_vaddr);
      end
      // a block shown in the redirect cycle is still an old one
      if (i_fetch_blk.valid && i_ibuf_ready) begin
        check_block(i_fetch_blk.vaddr, i_fetch_blk.data);
      end
      if (i_commit.valid || (i_br_upd.valid && i_br_upd.mispredict)) begin
        pending = 1'b1;
      end
      if (i_br_upd.valid && i_br_upd.mispredict) begin
        upd_idx            = btb_index(i_br_upd.pc);
        ref_valid[upd_idx] = 1'b1;
        ref_blk[upd_idx]   = align_blk(i_br_upd.pc);
        ref_tgt[upd_idx]   = align_blk(i_br_upd.target);
      end
    end
    r_busy <= pending;
  end

  assign o_busy   = r_busy;
  assign o_errors = errors;
  assign o_checks = checks;

endmodule

// File: tb/fe_testdata.txt
// columns in hex: delay kind cause_or_csr epc_or_value br_pc br_target expected
// kind 0 commit, 1 mispredict, 2 csr (0 mtvec 1 stvec 2 mepc 3 sepc 4 medeleg), 3 both
0 2 0 8000 0 0 0
0 2 1 9000 0 0 0
0 2 2 2224 0 0 0
0 2 3 333c 0 0 0
0 2 4 2100 0 0 0
6 0 b 1100 0 0 8000
6 0 8 8010 0 0 9000
6 0 d 9020 0 0 9000
6 0 5 9040 0 0 8000
6 0 3 8040 0 0 2220
6 0 a 2240 0 0 3338
6 0 2 3354 0 0 3358
6 0 2 335c 0 0 3360
6 1 0 0 3370 5000 5000
6 1 0 0 5014 6004 6000
6 1 0 0 6100 3360 3360
20 0 9 4000 0 0 8000
6 3 7 8020 8028 7000 8000
6 3 3 8000 7010 7400 2220
8 0 f 2230 0 0 8000
4 1 0 0 8010 4444 4440
4 0 c 4450 0 0 8000
0 2 4 1001 0 0 0
6 0 0 8008 0 0 9000
6 0 c 9010 0 0 9000

// File: tb/tb_fe_top.sv
/* fetch front end testbench */
`timescale 1ns/1ps
`include "fe_defines.svh"

module tb_fe_top
  import fe_pkg::*;
();

  localparam int N_EVENTS   = 25;
  localparam int REC_WORDS  = 7;    // words per event line
  localparam int WAIT_LIMIT = 200;  // cycles

  logic                   clk;
  logic                   reset_n;
  fe_commit_t             commit;
  fe_csr_t                csr;
  fe_br_upd_t             br_upd;
  fe_fetch_req_t          fetch_req;
  logic                   fetch_ready;
  logic [`FE_BLK_W-1:0]   fetch_data;
  fe_fetch_blk_t          fetch_blk;
  logic                   ibuf_ready;

  logic                   exp_valid;
  logic [`FE_VADDR_W-1:0] exp_vaddr;
  logic                   chk_busy;
  int                     chk_errors;
  int                     chk_checks;

  logic [63:0]            testdata [N_EVENTS*REC_WORDS];
  logic [31:0]            rng_state;
  logic                   mem_take;
  logic [`FE_VADDR_W-1:0] mem_addr;
  int                     tb_errors;
  bit                     abort;

  fe_top u_fe_top (
    .i_clk         (clk),
    .i_reset_n     (reset_n),
    .i_commit      (commit),
    .i_csr         (csr),
    .i_br_upd      (br_upd),
    .o_fetch_req   (fetch_req),
    .i_fetch_ready (fetch_ready),
    .i_fetch_data  (fetch_data),
    .o_fetch_blk   (fetch_blk),
    .i_ibuf_ready  (ibuf_ready)
  );

  fe_checker u_checker (
    .i_clk        (clk),
    .i_reset_n    (reset_n),
    .i_commit     (commit),
    .i_br_upd     (br_upd),
    .i_fetch_req  (fetch_req),
    .i_fetch_blk  (fetch_blk),
    .i_ibuf_ready (ibuf_ready),
    .i_exp_valid  (exp_valid),
    .i_exp_vaddr  (exp_vaddr),
    .o_busy       (chk_busy),
    .o_errors     (chk_errors),
    .o_checks     (chk_checks)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // ==================================================
  // memory model and random ready
  // ==================================================
  always @(posedge clk) begin
    mem_take  = fetch_req.valid && fetch_ready;
    mem_addr  = fetch_req.vaddr;
    rng_state = xorshift32(rng_state);
    #1;
    if (mem_take) begin
      fetch_data = {2{mem_addr[`FE_BLK_W/2-1:0]}};
    end else begin
      fetch_data = 64'hbad0_bad0_bad0_bad0;   // junk outside the data cycle
    end
    fetch_ready = (rng_state[1:0] != 2'b00);  // low a quarter of the time
    ibuf_ready  = (rng_state[9:8] != 2'b00);
  end

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic set_csr(input logic [63:0] id, input logic [63:0] value);
    case (id)
      0 : csr.mtvec   = value;
      1 : csr.stvec   = value;
      2 : csr.mepc    = value;
      3 : csr.sepc    = value;
      4 : csr.medeleg = value;
      default : begin
        $display("event names unknown csr %0d", id);
        tb_errors++;
      end
    endcase
  endtask

  task automatic wait_accept(input int n, output bit ok);
    int cycles;
    bit taken;
    cycles = 0;
    taken  = 1'b0;
    while (!taken && cycles < WAIT_LIMIT) begin
      @(posedge clk);
      taken = fetch_req.valid && fetch_ready;
      #1;
      if (cycles == 0) begin
        commit = '0;    // events last one cycle
        br_upd = '0;
      end
      cycles++;
    end
    if (!taken) begin
      $display("no fetch request accepted within %0d cycles of event %0d", WAIT_LIMIT, n);
      tb_errors++;
    end
    ok = taken;
  endtask

  task automatic wait_landed(input int n, output bit ok);
    int cycles;
    bit idle;
    cycles = 0;
    idle   = 1'b0;
    while (!idle && cycles < WAIT_LIMIT) begin
      @(posedge clk);
      idle = !chk_busy;
      #1;
      cycles++;
    end
    if (!idle) begin
      $display("no block taken within %0d cycles after the redirect of event %0d",
               WAIT_LIMIT, n);
      tb_errors++;
    end
    ok = idle;
  endtask

  // ==================================================
  // one event from the data file
  // ==================================================
  task automatic run_event(input int n);
    logic [63:0] w [REC_WORDS];
    bit          ok;
    foreach (w[i])
      w[i] = testdata[n*REC_WORDS + i];
    idle_cycles(int'(w[0]));
    ok = 1'b1;
    case (w[1])
      0, 1, 3 : begin
        if (w[1] != 1) begin
          commit.valid = 1'b1;
          commit.cause = fe_cause_t'(w[2][3:0]);
          commit.epc   = w[3][`FE_VADDR_W-1:0];
        end
        if (w[1] != 0) begin
          br_upd.valid      = 1'b1;
          br_upd.mispredict = 1'b1;
          br_upd.pc         = w[4][`FE_VADDR_W-1:0];
          br_upd.target     = w[5][`FE_VADDR_W-1:0];
        end
        wait_accept(n, ok);
        if (ok) begin
          exp_valid = 1'b1;   // restart address to the checker
          exp_vaddr = w[6][`FE_VADDR_W-1:0];
          idle_cycles(1);
          exp_valid = 1'b0;
          wait_landed(n, ok);
        end
      end
      2 : set_csr(w[2], w[3]);
      default : begin
        $display("event %0d has unknown kind %0d", n, w[1]);
        tb_errors++;
      end
    endcase
    if (!ok) begin
      abort = 1'b1;
    end
  endtask

  initial begin
    clk         = 1'b0;
    reset_n     = 1'b0;
    commit      = '0;
    csr         = '0;
    br_upd      = '0;
    fetch_ready = 1'b0;
    fetch_data  = '0;
    ibuf_ready  = 1'b0;
    exp_valid   = 1'b0;
    exp_vaddr   = '0;
    rng_state   = 32'd60589;
    tb_errors   = 0;
    abort       = 1'b0;
    $readmemh("tb/fe_testdata.txt", testdata);
    idle_cycles(4);
    reset_n = 1'b1;
    for (int ev = 0; ev < N_EVENTS && !abort; ev++) begin
      run_event(ev);
    end
    if (!abort) begin
      idle_cycles(40);    // let sequential fetch run on
    end
    if (chk_checks == 0) begin
      $display("no fetch block was taken during the run");
      tb_errors++;
    end
    $display("blocks checked %0d, checker errors %0d, testbench errors %0d",
             chk_checks, chk_errors, tb_errors);
    if (chk_errors == 0 && tb_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: verilog/fe_btb.sv
/* branch target buffer */
`timescale 1ns/1ps
`include "fe_defines.svh"

module fe_btb
  import fe_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_reset_n,
  input  logic                   i_s0_valid,
  input  logic [`FE_VADDR_W-1:0] i_s0_vaddr,
  input  fe_br_upd_t             i_br_upd,
  output fe_btb_hit_t            o_s1_hit
);

  localparam int BLK_OFS_W = $clog2(`FE_BLK_BYTES);
  localparam int IDX_W     = $clog2(`FE_BTB_ENTRIES);
  localparam int TAG_W     = `FE_VADDR_W - BLK_OFS_W - IDX_W;

  logic [`FE_BTB_ENTRIES-1:0] r_valid;
  logic [TAG_W-1:0]           r_tag    [`FE_BTB_ENTRIES];
  logic [`FE_VADDR_W-1:0]     r_target [`FE_BTB_ENTRIES];

  logic [IDX_W-1:0]       w_s0_idx;
  logic [TAG_W-1:0]       w_s0_tag;
  logic [IDX_W-1:0]       w_upd_idx;
  logic [TAG_W-1:0]       w_upd_tag;
  logic                   w_upd_valid;
  logic                   r_s1_hit;
  logic [`FE_VADDR_W-1:0] r_s1_target;

  // index and tag come from the block address
  assign w_s0_idx  = i_s0_vaddr[BLK_OFS_W +: IDX_W];
  assign w_s0_tag  = i_s0_vaddr[`FE_VADDR_W-1 -: TAG_W];
  assign w_upd_idx = i_br_upd.pc[BLK_OFS_W +: IDX_W];
  assign w_upd_tag = i_br_upd.pc[`FE_VADDR_W-1 -: TAG_W];

  assign w_upd_valid = i_br_upd.valid & i_br_upd.mispredict;  // train on mispredict only

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= '0;
    end else if (w_upd_valid) begin
      r_valid[w_upd_idx] <= 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_upd_valid) begin
      r_tag[w_upd_idx]    <= w_upd_tag;
      r_target[w_upd_idx] <= i_br_upd.target;
    end
  end

  // lookup result lands in stage 1
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_s1_hit <= 1'b0;
    end else begin
      r_s1_hit <= i_s0_valid & r_valid[w_s0_idx] & (r_tag[w_s0_idx] == w_s0_tag);
    end
  end

  always_ff @(posedge i_clk) begin
    r_s1_target <= r_target[w_s0_idx];
  end

  assign o_s1_hit.hit    = r_s1_hit;
  assign o_s1_hit.target = r_s1_target;

  a_hit_has_lookup : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_s1_hit.hit |-> $past(i_s0_valid));

endmodule

// File: verilog/fe_defines.svh
/* fetch front end parameters */
`ifndef FE_DEFINES_SVH
`define FE_DEFINES_SVH

// ==================================================
// widths
// ==================================================
`define FE_VADDR_W 39   // sv39 virtual address
`define FE_XLEN 64      // csr width

// ==================================================
// fetch block
// ==================================================
`define FE_BLK_BYTES 8  // bytes per fetch block
`define FE_BLK_W 64     // instruction bits per block

// reset fetch address, block aligned
`define FE_PC_INIT 39'h00_0000_1000

// ==================================================
// branch target buffer
// ==================================================
`define FE_BTB_ENTRIES 16  // direct mapped, power of two

`endif

// File: verilog/fe_fetch_pipe.sv
/* fetch stages 1 and 2 */
`timescale 1ns/1ps
`include "fe_defines.svh"

module fe_fetch_pipe
  import fe_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_reset_n,
  input  logic                   i_s0_accept,
  input  logic [`FE_VADDR_W-1:0] i_s0_vaddr,
  input  logic                   i_redirect_valid,
  input  logic                   i_s1_btb_hit,
  input  logic [`FE_BLK_W-1:0]   i_fetch_data,
  input  logic                   i_ibuf_ready,
  output logic                   o_s1_live,
  output logic                   o_s2_stall,
  output logic [`FE_VADDR_W-1:0] o_s2_vaddr,
  output fe_fetch_blk_t          o_fetch_blk
);

  logic                   r_s1_valid;
  logic [`FE_VADDR_W-1:0] r_s1_vaddr;
  logic                   r_s2_valid;
  logic                   r_s2_clear;   // killed while in stage 1
  logic [`FE_VADDR_W-1:0] r_s2_vaddr;
  logic [`FE_BLK_W-1:0]   r_s2_data;

  logic w_s2_live;
  logic w_s1_kill;
  logic w_s2_hold;

  // ==================================================
  // kill and hold
  // ==================================================
  assign w_s2_live  = r_s2_valid & ~r_s2_clear;
  assign o_s2_stall = w_s2_live & ~i_ibuf_ready;

  // predicted block is dropped, fetch jumps to the target
  assign w_s1_kill = i_redirect_valid | (i_s1_btb_hit & r_s1_valid) | o_s2_stall;
  assign w_s2_hold = o_s2_stall & ~i_redirect_valid;  // refused block stays put

  assign o_s1_live = r_s1_valid;

  // ==================================================
  // stage registers
  // ==================================================
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_s1_valid <= 1'b0;
      r_s2_valid <= 1'b0;
      r_s2_clear <= 1'b0;
    end else begin
      r_s1_valid <= i_s0_accept;
      if (!w_s2_hold) begin
        r_s2_valid <= r_s1_valid;
        r_s2_clear <= w_s1_kill;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    r_s1_vaddr <= i_s0_vaddr;
    if (!w_s2_hold) begin
      r_s2_vaddr <= r_s1_vaddr;
      r_s2_data  <= i_fetch_data;   // memory answers in stage 1
    end
  end

  assign o_s2_vaddr        = r_s2_vaddr;
  assign o_fetch_blk.valid = w_s2_live;
  assign o_fetch_blk.vaddr = r_s2_vaddr;
  assign o_fetch_blk.data  = r_s2_data;

  // the replay in fe_pc_ctrl resumes after this block, so it must not move
  a_blk_stable : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_fetch_blk.valid && !i_ibuf_ready && !i_redirect_valid |=>
      o_fetch_blk.valid && $stable(o_fetch_blk.vaddr));

endmodule

// File: verilog/fe_pc_ctrl.sv
/* fetch state machine and stage 0 */
`timescale 1ns/1ps
`include "fe_defines.svh"

module fe_pc_ctrl
  import fe_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_reset_n,
  input  fe_redirect_t           i_redirect,
  input  logic                   i_fetch_ready,
  input  fe_btb_hit_t            i_s1_btb,
  input  logic                   i_s1_live,
  input  logic                   i_s2_stall,
  input  logic [`FE_VADDR_W-1:0] i_s2_vaddr,
  output fe_fetch_req_t          o_fetch_req,
  output logic                   o_s0_accept
);

  localparam int BLK_OFS_W = $clog2(`FE_BLK_BYTES);
  localparam logic [`FE_VADDR_W-1:0] BLK_BYTES = `FE_BLK_BYTES;

  function automatic logic [`FE_VADDR_W-1:0] blk_align(input logic [`FE_VADDR_W-1:0] a);
    blk_align = {a[`FE_VADDR_W-1:BLK_OFS_W], {BLK_OFS_W{1'b0}}};
  endfunction

  fe_state_t              r_state;
  fe_state_t              w_state_next;
  logic [`FE_VADDR_W-1:0] r_s0_vaddr;       // next block to request
  logic [`FE_VADDR_W-1:0] w_s0_vaddr_next;
  logic [`FE_VADDR_W-1:0] w_s0_vaddr;       // block requested this cycle
  logic                   w_s1_predict;
  logic                   w_req_valid;

  // ==================================================
  // stage 0 address
  // ==================================================
  assign w_s1_predict = i_s1_live & i_s1_btb.hit;

  always_comb begin
    if (i_redirect.valid) begin
      w_s0_vaddr = blk_align(i_redirect.vaddr);
    end else if (w_s1_predict) begin
      w_s0_vaddr = blk_align(i_s1_btb.target);  // predicted taken
    end else begin
      w_s0_vaddr = r_s0_vaddr;
    end
  end

  // a refused block blocks new requests, a redirect never waits for it
  assign w_req_valid = (r_state != INIT) & (i_redirect.valid | ~i_s2_stall);
  assign o_s0_accept = w_req_valid & i_fetch_ready;

  assign o_fetch_req.valid = w_req_valid;
  assign o_fetch_req.vaddr = w_s0_vaddr;

  // ==================================================
  // state machine
  // ==================================================
  always_comb begin
    w_state_next    = r_state;
    w_s0_vaddr_next = r_s0_vaddr;
    case (r_state)
      INIT : begin
        w_state_next = FETCH_REQ;
        if (i_redirect.valid) begin
          w_s0_vaddr_next = w_s0_vaddr;
        end
      end
      FETCH_REQ,
      WAIT_IBUF_FREE,
      WAIT_FLUSH_FREE : begin
        if (i_redirect.valid & ~i_fetch_ready) begin
          w_state_next    = WAIT_FLUSH_FREE;  // hold target until accepted
          w_s0_vaddr_next = w_s0_vaddr;
        end else if (~i_redirect.valid & i_s2_stall) begin
          // block in stage 2 is held, resume right after it
          w_state_next    = WAIT_IBUF_FREE;
          w_s0_vaddr_next = i_s2_vaddr + BLK_BYTES;
        end else if (o_s0_accept) begin
          w_state_next    = FETCH_REQ;
          w_s0_vaddr_next = w_s0_vaddr + BLK_BYTES;
        end else begin
          w_s0_vaddr_next = w_s0_vaddr;       // keeps a btb target too
          if (r_state == WAIT_IBUF_FREE) begin
            w_state_next = FETCH_REQ;
          end
        end
      end
      default : begin
        w_state_next = INIT;
      end
    endcase
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state    <= INIT;
      r_s0_vaddr <= `FE_PC_INIT;
    end else begin
      r_state    <= w_state_next;
      r_s0_vaddr <= w_s0_vaddr_next;
    end
  end

  // ==================================================
  // checks
  // ==================================================
  a_req_aligned : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_fetch_req.valid |-> (o_fetch_req.vaddr[BLK_OFS_W-1:0] == '0));

  // INIT is a single idle cycle
  a_init_idle : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (r_state == INIT) |-> !o_fetch_req.valid ##1 (r_state != INIT));

endmodule

// File: verilog/fe_pkg.sv
/* front end types */
`include "fe_defines.svh"

package fe_pkg;

  // commit causes, fault and ecall codes match their medeleg bit
  typedef enum logic [3:0] {
    INST_ADDR_MISALIGN  = 4'd0,
    INST_ACC_FAULT      = 4'd1,
    SILENT_FLUSH        = 4'd2,   // restart after the flushing inst
    MRET                = 4'd3,
    LOAD_ADDR_MISALIGN  = 4'd4,
    LOAD_ACC_FAULT      = 4'd5,
    STAMO_ADDR_MISALIGN = 4'd6,
    STAMO_ACC_FAULT     = 4'd7,
    ECALL_U             = 4'd8,
    ECALL_S             = 4'd9,
    SRET                = 4'd10,
    ECALL_M             = 4'd11,
    INST_PAGE_FAULT     = 4'd12,
    LOAD_PAGE_FAULT     = 4'd13,
    STAMO_PAGE_FAULT    = 4'd15
  } fe_cause_t;

  typedef enum logic [2:0] {
    INIT            = 3'd0,
    FETCH_REQ       = 3'd1,
    WAIT_IBUF_FREE  = 3'd2,
    WAIT_FLUSH_FREE = 3'd3
  } fe_state_t;

  typedef struct packed {
    logic                   valid;
    fe_cause_t              cause;
    logic [`FE_VADDR_W-1:0] epc;
  } fe_commit_t;

  typedef struct packed {
    logic [`FE_XLEN-1:0] mtvec;
    logic [`FE_XLEN-1:0] stvec;
    logic [`FE_XLEN-1:0] mepc;
    logic [`FE_XLEN-1:0] sepc;
    logic [`FE_XLEN-1:0] medeleg;
  } fe_csr_t;

  // resolved branch from execute
  typedef struct packed {
    logic                   valid;
    logic                   mispredict;
    logic [`FE_VADDR_W-1:0] pc;
    logic [`FE_VADDR_W-1:0] target;
  } fe_br_upd_t;

  typedef struct packed {
    logic                   valid;
    logic [`FE_VADDR_W-1:0] vaddr;
  } fe_fetch_req_t;

  typedef struct packed {
    logic                   valid;
    logic [`FE_VADDR_W-1:0] vaddr;
    logic [`FE_BLK_W-1:0]   data;
  } fe_fetch_blk_t;

  typedef struct packed {
    logic                   valid;
    logic [`FE_VADDR_W-1:0] vaddr;
  } fe_redirect_t;

  typedef struct packed {
    logic                   hit;
    logic [`FE_VADDR_W-1:0] target;
  } fe_btb_hit_t;

endpackage

// File: verilog/fe_redirect_sel.sv
/* redirect source select */
`timescale 1ns/1ps
`include "fe_defines.svh"

module fe_redirect_sel
  import fe_pkg::*;
(
  input  fe_commit_t   i_commit,
  input  fe_csr_t      i_csr,
  input  fe_br_upd_t   i_br_upd,
  output fe_redirect_t o_redirect
);

  localparam logic [`FE_VADDR_W-1:0] INST_BYTES = 4;

  logic [`FE_VADDR_W-1:0] w_trap_vaddr;
  logic [`FE_VADDR_W-1:0] w_commit_vaddr;
  logic                   w_cause_known;
  logic                   w_br_flush;

  // delegated causes go to the supervisor vector
  assign w_trap_vaddr = i_csr.medeleg[i_commit.cause] ? i_csr.stvec[`FE_VADDR_W-1:0] :
                                                        i_csr.mtvec[`FE_VADDR_W-1:0];

  always_comb begin
    w_cause_known = 1'b1;
    case (i_commit.cause)
      SILENT_FLUSH : w_commit_vaddr = i_commit.epc + INST_BYTES;
      MRET         : w_commit_vaddr = i_csr.mepc[`FE_VADDR_W-1:0];
      SRET         : w_commit_vaddr = i_csr.sepc[`FE_VADDR_W-1:0];
      INST_ADDR_MISALIGN,
      INST_ACC_FAULT,
      LOAD_ADDR_MISALIGN,
      LOAD_ACC_FAULT,
      STAMO_ADDR_MISALIGN,
      STAMO_ACC_FAULT,
      ECALL_U,
      ECALL_S,
      ECALL_M,
      INST_PAGE_FAULT,
      LOAD_PAGE_FAULT,
      STAMO_PAGE_FAULT : w_commit_vaddr = w_trap_vaddr;  // trap entry
      default : begin
        w_commit_vaddr = '0;
        w_cause_known  = 1'b0;
      end
    endcase
  end

  assign w_br_flush = i_br_upd.valid & i_br_upd.mispredict;

  // commit is older than anything in execute, so it always wins
  assign o_redirect.valid = i_commit.valid | w_br_flush;
  assign o_redirect.vaddr = i_commit.valid ? w_commit_vaddr : i_br_upd.target;

  // a committed cause without a restart address would send fetch to zero
  a_cause_known : assert final (!i_commit.valid || w_cause_known)
    else $error("undefined commit cause %0d", i_commit.cause);

endmodule

// File: verilog/fe_top.sv
/* instruction fetch front end */
`timescale 1ns/1ps
`include "fe_defines.svh"

module fe_top
  import fe_pkg::*;
(
  input  logic                 i_clk,
  input  logic                 i_reset_n,
  input  fe_commit_t           i_commit,
  input  fe_csr_t              i_csr,
  input  fe_br_upd_t           i_br_upd,
  output fe_fetch_req_t        o_fetch_req,
  input  logic                 i_fetch_ready,
  input  logic [`FE_BLK_W-1:0] i_fetch_data,
  output fe_fetch_blk_t        o_fetch_blk,
  input  logic                 i_ibuf_ready
);

  fe_redirect_t           w_redirect;
  fe_btb_hit_t            w_s1_btb;
  logic                   w_s0_accept;
  logic                   w_s1_live;
  logic                   w_s2_stall;
  logic [`FE_VADDR_W-1:0] w_s2_vaddr;

  // ==================================================
  // redirect and stage 0
  // ==================================================
  fe_redirect_sel u_redirect_sel (
    .i_commit   (i_commit),
    .i_csr      (i_csr),
    .i_br_upd   (i_br_upd),
    .o_redirect (w_redirect)
  );

  fe_pc_ctrl u_pc_ctrl (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_redirect    (w_redirect),
    .i_fetch_ready (i_fetch_ready),
    .i_s1_btb      (w_s1_btb),
    .i_s1_live     (w_s1_live),
    .i_s2_stall    (w_s2_stall),
    .i_s2_vaddr    (w_s2_vaddr),
    .o_fetch_req   (o_fetch_req),
    .o_s0_accept   (w_s0_accept)
  );

  // ==================================================
  // prediction and fetch stages
  // ==================================================
  fe_btb u_btb (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_s0_valid (w_s0_accept),        // look up accepted blocks only
    .i_s0_vaddr (o_fetch_req.vaddr),
    .i_br_upd   (i_br_upd),
    .o_s1_hit   (w_s1_btb)
  );

  fe_fetch_pipe u_fetch_pipe (
    .i_clk            (i_clk),
    .i_reset_n        (i_reset_n),
    .i_s0_accept      (w_s0_accept),
    .i_s0_vaddr       (o_fetch_req.vaddr),
    .i_redirect_valid (w_redirect.valid),
    .i_s1_btb_hit     (w_s1_btb.hit),
    .i_fetch_data     (i_fetch_data),
    .i_ibuf_ready     (i_ibuf_ready),
    .o_s1_live        (w_s1_live),
    .o_s2_stall       (w_s2_stall),
    .o_s2_vaddr       (w_s2_vaddr),
    .o_fetch_blk      (o_fetch_blk)
  );

endmodule
